/* vlog.f */
+incdir+hdl
hdl/maze_pkg.sv
hdl/player_motion.sv
hdl/bomb_table.sv
hdl/game_sequencer.sv
hdl/maze_game.sv
sim/maze_ram_model.sv
sim/tb_maze_game.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the maze game testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_maze_game -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
RUN_STATUS=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
   echo "Simulation reported failure"
   exit 1
fi

if [ $RUN_STATUS -ne 0 ]; then
   echo "Simulation exited with status $RUN_STATUS"
   exit 1
fi

exit 0

/* sim/tb_maze_game.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maze_consts.svh"

module tb_maze_game;

   import maze_pkg::*;

   localparam int NUM_FRAMES = 382;
   localparam int FRAME_CYC  = 202;
   localparam int NUM_RAND   = 8;
   // Reset, sweep wait, every frame, plus slack
   localparam int CYCLE_LIMIT = 10 + 1200 + NUM_FRAMES * FRAME_CYC + 1000;

   logic       clk;
   logic       reset_n;
   logic       eof;
   pad_t       pad1;
   pad_t       pad2;
   pos_t       player1_pos;
   pos_t       player2_pos;
   tile_addr_u maze_raddr;
   logic [3:0] maze_rdata;
   maze_wr_t   maze_wr;

   int         cycle_count;
   int         frame_no;
   int         writes_at_start;
   int         rand_addr [NUM_RAND];
   event       frame_done;

   maze_game DUT (
      .clk         (clk),
      .reset_n     (reset_n),
      .eof         (eof),
      .pad1        (pad1),
      .pad2        (pad2),
      .player1_pos (player1_pos),
      .player2_pos (player2_pos),
      .maze_raddr  (maze_raddr),
      .maze_rdata  (maze_rdata),
      .maze_wr     (maze_wr)
   );

   maze_ram_model RAM (
      .clk   (clk),
      .raddr (maze_raddr),
      .rdata (maze_rdata),
      .wr    (maze_wr)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Flat maze address of a tile
   function automatic int tile_addr(input int row, input int col);
      return row * 32 + col;
   endfunction

   // Pixel coordinate after some frames of a one-tile move, landing clamps
   function automatic int ref_coord(input int start_px, input int speed,
                                    input int sgn, input int steps);
      int travel;
      travel = speed * steps;
      if (travel > `TILE_PX * 16)
         travel = `TILE_PX * 16;
      return (start_px * 16 + sgn * travel) >>> `FRAC_BITS;
   endfunction

   // Frame in which a bomb disappears, drop frame counts as the first
   function automatic int bomb_expiry(input int drop_frame);
      return drop_frame + `BOMB_FUSE - 1;
   endfunction

   // Player 1 schedule: blocked left, one tile right, pause, gate, wall
   function automatic int p1_x_ref(input int n);
      if (n <= 4)
         return 128;
      else if (n <= 20)
         return ref_coord(128, 32, 1, n - 4);
      else if (n <= 24)
         return 160;
      else if (n <= 40)
         return ref_coord(160, 32, 1, n - 24);
      return 192;
   endfunction

   // Player 2 moves up one tile at the slow speed
   function automatic int p2_y_ref(input int n);
      if (n <= 171)
         return ref_coord(448, 3, -1, n);
      return 416;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Fail %s got %0h expected %0h", name, got, exp);
         $display("TEST FAIL");
         $fatal(1);
      end
   endtask

   // Empty maze with gates, a wall and random bombs in rows 0 to 2
   task automatic preload_maze();
      for (int a = 0; a < 1024; a++)
         RAM.mem[a] = `TILE_EMPTY;
      RAM.mem[tile_addr(4, 3)]   = `GATE_RIGHT;
      RAM.mem[tile_addr(4, 6)]   = `GATE_RIGHT;
      RAM.mem[tile_addr(4, 7)]   = `TILE_WALL1;
      RAM.mem[tile_addr(16, 24)] = `TILE_WALL2;
      for (int i = 0; i < NUM_RAND; i++)
      begin
         rand_addr[i] = tile_addr($urandom % 3, $urandom % 25);
         RAM.mem[rand_addr[i]] = `TILE_BOMB;
      end
   endtask

   task automatic set_pads(input int n);
      pad1 = '0;
      pad2 = '0;
      pad1.left  = (n <= 4);
      pad1.right = (n >= 5 && n <= 20) || (n >= 25 && n <= 44);
      pad1.drop  = (n == 21 || n == 22);
      pad2.up    = (n <= 171);
      pad2.drop  = (n == 1);
      pad2.down  = (n >= 172 && n <= 175);
   endtask

   // One eof pulse, then idle cycles well past the frame bound
   task automatic run_frame(input int n);
      @(posedge clk);
      #2;
      writes_at_start = RAM.write_count;
      eof = 1'b1;
      set_pads(n);
      @(posedge clk);
      #2;
      eof = 1'b0;
      repeat (200) @(posedge clk);
      #1;
      frame_no = n;
      ->frame_done;
   endtask

   // Compare against the reference after every frame
   always @(frame_done)
   begin
      check_val("player1_pos.x", 32'(player1_pos.x), p1_x_ref(frame_no));
      check_val("player1_pos.y", 32'(player1_pos.y), 128);
      check_val("player2_pos.x", 32'(player2_pos.x), 448);
      check_val("player2_pos.y", 32'(player2_pos.y), p2_y_ref(frame_no));
      // Player 2 bomb dropped in frame 1
      check_val("tile_14_14", RAM.mem[tile_addr(14, 14)],
                (frame_no < bomb_expiry(1)) ? `TILE_BOMB : `TILE_EMPTY);
      // Player 1 bomb dropped in frame 21
      check_val("tile_4_5", RAM.mem[tile_addr(4, 5)],
                (frame_no >= 21 && frame_no < bomb_expiry(21)) ? `TILE_BOMB : `TILE_EMPTY);
      // Gate turns round when passed
      check_val("tile_4_6", RAM.mem[tile_addr(4, 6)],
                (frame_no < 25) ? `GATE_RIGHT : `GATE_LEFT);
      check_val("tile_4_3", RAM.mem[tile_addr(4, 3)], `GATE_RIGHT);
      check_val("tile_4_7", RAM.mem[tile_addr(4, 7)], `TILE_WALL1);
      if (frame_no == 21)
      begin
         check_val("maze_wr_count", RAM.write_count - writes_at_start, 1);
         // The single write of the drop lands on the rounded tile
         check_val("maze_wr.addr", RAM.last_addr.flat, tile_addr(4, 5));
         check_val("maze_wr.code", RAM.last_code, `TILE_BOMB);
      end
      // Second drop on an occupied tile
      if (frame_no == 22)
         check_val("maze_wr_count", RAM.write_count - writes_at_start, 0);
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > CYCLE_LIMIT)
      begin
         $display("Timeout: the run went past its cycle limit without finishing");
         $display("TEST FAIL");
         $fatal(1);
      end
   end

   initial
   begin
      void'($urandom(99));
      cycle_count     = 0;
      frame_no        = 0;
      writes_at_start = 0;
      reset_n         = 1'b0;
      eof             = 1'b0;
      pad1            = '0;
      pad2            = '0;
      preload_maze();
      repeat (10) @(posedge clk);
      #2;
      reset_n = 1'b1;
      repeat (1200) @(posedge clk);
      #1;
      // Sweep removed the bombs only
      for (int i = 0; i < NUM_RAND; i++)
         check_val("swept_bomb_tile", RAM.mem[rand_addr[i]], `TILE_EMPTY);
      check_val("tile_16_24", RAM.mem[tile_addr(16, 24)], `TILE_WALL2);
      check_val("tile_4_6", RAM.mem[tile_addr(4, 6)], `GATE_RIGHT);
      for (int n = 1; n <= NUM_FRAMES; n++)
         run_frame(n);
      @(posedge clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* sim/maze_ram_model.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maze_consts.svh"

module maze_ram_model (
   input  wire                        clk,
   input  wire maze_pkg::tile_addr_u  raddr,
   output logic [3:0]                 rdata,
   input  wire maze_pkg::maze_wr_t    wr
);

   import maze_pkg::*;

   // Whole 10-bit address space, the sweep only touches the first 544
   logic [3:0] mem [1024];

   // Write log
   int         write_count;
   tile_addr_u last_addr;
   logic [3:0] last_code;

   initial
   begin
      write_count = 0;
      last_addr   = '0;
      last_code   = '0;
      rdata       = '0;
   end

   // Registered read, data shows one edge after the address is sampled
   always @(posedge clk)
   begin
      rdata <= mem[raddr.flat];
   end

   // Write takes effect at the edge
   always @(posedge clk)
   begin
      if (wr.we)
      begin
         mem[wr.addr.flat] <= wr.code;
         write_count       <= write_count + 1;
         last_addr         <= wr.addr;
         last_code         <= wr.code;
      end
   end

endmodule

`default_nettype wire

/* hdl/maze_game.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maze_consts.svh"

module maze_game (
   input  wire                        clk,
   input  wire                        reset_n,
   input  wire                        eof,
   input  wire maze_pkg::pad_t        pad1,
   input  wire maze_pkg::pad_t        pad2,
   output maze_pkg::pos_t             player1_pos,
   output maze_pkg::pos_t             player2_pos,
   output maze_pkg::tile_addr_u       maze_raddr,
   input  wire [3:0]                  maze_rdata,
   output maze_pkg::maze_wr_t         maze_wr
);

   import maze_pkg::*;

   // Sequencer to players
   move_cmd_t                        p1_cmd;
   move_cmd_t                        p2_cmd;
   logic                             p1_moving;
   logic                             p2_moving;
   dir_t                             p1_dir;
   dir_t                             p2_dir;
   tile_pos_t                        p1_goal;
   tile_pos_t                        p2_goal;

   // Sequencer to bomb table
   logic [$clog2(`BOMB_SLOTS)-1:0]   bomb_rd_idx;
   bomb_entry_t                      bomb_rd_entry;
   bomb_wr_t                         bomb_wr;

   game_sequencer u_seq (
      .clk           (clk),
      .reset_n       (reset_n),
      .eof           (eof),
      .pad1          (pad1),
      .pad2          (pad2),
      .p1_cmd        (p1_cmd),
      .p2_cmd        (p2_cmd),
      .p1_moving     (p1_moving),
      .p2_moving     (p2_moving),
      .p1_dir        (p1_dir),
      .p2_dir        (p2_dir),
      .p1_goal       (p1_goal),
      .p2_goal       (p2_goal),
      .p1_pos        (player1_pos),
      .p2_pos        (player2_pos),
      .maze_raddr    (maze_raddr),
      .maze_rdata    (maze_rdata),
      .maze_wr       (maze_wr),
      .bomb_rd_idx   (bomb_rd_idx),
      .bomb_rd_entry (bomb_rd_entry),
      .bomb_wr       (bomb_wr)
   );

   // Player 1 fast, player 2 slow
   player_motion #(
      .START_X (128),
      .START_Y (128),
      .SPEED   (32)
   ) u_player1 (
      .clk       (clk),
      .reset_n   (reset_n),
      .cmd       (p1_cmd),
      .pos       (player1_pos),
      .moving    (p1_moving),
      .dir       (p1_dir),
      .goal_tile (p1_goal)
   );

   player_motion #(
      .START_X (448),
      .START_Y (448),
      .SPEED   (3)
   ) u_player2 (
      .clk       (clk),
      .reset_n   (reset_n),
      .cmd       (p2_cmd),
      .pos       (player2_pos),
      .moving    (p2_moving),
      .dir       (p2_dir),
      .goal_tile (p2_goal)
   );

   bomb_table u_bombs (
      .clk      (clk),
      .rd_idx   (bomb_rd_idx),
      .rd_entry (bomb_rd_entry),
      .wr       (bomb_wr)
   );

endmodule

`default_nettype wire

/* hdl/game_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maze_consts.svh"

module game_sequencer (
   input  wire                               clk,
   input  wire                               reset_n,
   input  wire                               eof,
   input  wire maze_pkg::pad_t               pad1,
   input  wire maze_pkg::pad_t               pad2,
   output maze_pkg::move_cmd_t               p1_cmd,
   output maze_pkg::move_cmd_t               p2_cmd,
   input  wire                               p1_moving,
   input  wire                               p2_moving,
   input  wire maze_pkg::dir_t               p1_dir,
   input  wire maze_pkg::dir_t               p2_dir,
   input  wire maze_pkg::tile_pos_t          p1_goal,
   input  wire maze_pkg::tile_pos_t          p2_goal,
   input  wire maze_pkg::pos_t               p1_pos,
   input  wire maze_pkg::pos_t               p2_pos,
   output maze_pkg::tile_addr_u              maze_raddr,
   input  wire [3:0]                         maze_rdata,
   output maze_pkg::maze_wr_t                maze_wr,
   output logic [$clog2(`BOMB_SLOTS)-1:0]    bomb_rd_idx,
   input  wire maze_pkg::bomb_entry_t        bomb_rd_entry,
   output maze_pkg::bomb_wr_t                bomb_wr
);

   import maze_pkg::*;

   localparam int SLOT_W  = $clog2(`BOMB_SLOTS);
   localparam int TILE_SH = $clog2(`TILE_PX);
   localparam logic [SLOT_W-1:0]      SLOT_LAST = SLOT_W'(`BOMB_SLOTS - 1);
   localparam logic [`FUSE_W-1:0]     FUSE_FULL = `FUSE_W'(`BOMB_FUSE);
   localparam logic [`FUSE_W-1:0]     FUSE_ONE  = `FUSE_W'(1);
   localparam logic signed [`POS_W:0] HALF_PX   = (`POS_W + 1)'(`TILE_PX / 2);

   // Sweep, table clear, then per frame two motions, two drops and aging
   typedef enum logic [4:0] {
      S_CLR_WAIT, S_CLR_CHK, S_TBL_CLR, S_IDLE,
      S_MV_BEGIN, S_MV_GOAL, S_MV_ADDR, S_MV_WAIT, S_MV_CHK, S_MV_NEXT,
      S_DR_BEGIN, S_DR_WAIT, S_DR_CHK, S_DR_SCAN, S_DR_NEXT,
      S_AGE_LEAD, S_AGE_SCAN
   } state_t;

   state_t                   state;
   // Player served by the shared motion and drop states, 1 means player 2
   logic                     pl;
   move_cmd_t                cmd_q;
   // Slot whose entry shows on bomb_rd_entry in this cycle
   logic [SLOT_W-1:0]        chk_idx;

   logic                     cur_moving;
   dir_t                     cur_dir;
   tile_pos_t                cur_goal;
   pos_t                     cur_pos;
   pad_t                     cur_pad;

   logic                     key_any;
   dir_t                     key_dir;
   logic signed [`POS_W:0]   drop_x;
   logic signed [`POS_W:0]   drop_y;
   tile_pos_t                drop_tile;

   logic                     is_gate;
   logic                     gate_ok;
   logic                     blocked;
   logic [3:0]               flip_code;

   // Select the player being served
   assign cur_moving = pl ? p2_moving : p1_moving;
   assign cur_dir    = pl ? p2_dir : p1_dir;
   assign cur_goal   = pl ? p2_goal : p1_goal;
   assign cur_pos    = pl ? p2_pos : p1_pos;
   assign cur_pad    = pl ? pad2 : pad1;

   // Strobes go only to the player being served
   assign p1_cmd = pl ? move_cmd_t'('0) : cmd_q;
   assign p2_cmd = pl ? cmd_q : move_cmd_t'('0);

   // Key priority up, down, right, left
   always_comb
   begin
      key_any = cur_pad.up | cur_pad.down | cur_pad.right | cur_pad.left;
      if (cur_pad.up)
         key_dir = DIR_UP;
      else if (cur_pad.down)
         key_dir = DIR_DOWN;
      else if (cur_pad.right)
         key_dir = DIR_RIGHT;
      else
         key_dir = DIR_LEFT;
   end

   // Bomb lands on the tile the player mostly covers
   assign drop_x        = cur_pos.x + HALF_PX;
   assign drop_y        = cur_pos.y + HALF_PX;
   assign drop_tile.row = drop_y[TILE_SH +: `TILE_BITS];
   assign drop_tile.col = drop_x[TILE_SH +: `TILE_BITS];

   // Gate decode against the direction of the pending move
   always_comb
   begin
      gate_ok   = 1'b0;
      flip_code = maze_rdata;
      case (maze_rdata)
         `GATE_RIGHT:
         begin
            gate_ok   = (cur_dir == DIR_RIGHT);
            flip_code = `GATE_LEFT;
         end
         `GATE_LEFT:
         begin
            gate_ok   = (cur_dir == DIR_LEFT);
            flip_code = `GATE_RIGHT;
         end
         `GATE_UP:
         begin
            gate_ok   = (cur_dir == DIR_UP);
            flip_code = `GATE_DOWN;
         end
         `GATE_DOWN:
         begin
            gate_ok   = (cur_dir == DIR_DOWN);
            flip_code = `GATE_UP;
         end
         default:
            gate_ok = 1'b0;
      endcase
   end

   assign is_gate = maze_rdata inside {`GATE_RIGHT, `GATE_LEFT, `GATE_UP, `GATE_DOWN};
   // Walls, bombs and gates taken the wrong way stop the move
   assign blocked = (maze_rdata inside {`TILE_WALL1, `TILE_WALL2, `TILE_BOMB})
                    || (is_gate && !gate_ok);

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state       <= S_CLR_WAIT;
         pl          <= 1'b0;
         cmd_q       <= '0;
         maze_raddr  <= '0;
         maze_wr     <= '0;
         bomb_rd_idx <= '0;
         chk_idx     <= '0;
         bomb_wr     <= '0;
      end
      else
      begin
         // All strobes are single cycle
         cmd_q      <= '0;
         maze_wr.we <= 1'b0;
         bomb_wr.we <= 1'b0;
         // Table read has one cycle of latency
         chk_idx    <= bomb_rd_idx;
         case (state)
            // Clear sweep, one cycle for the RAM read then the check
            S_CLR_WAIT:
               state <= S_CLR_CHK;
            S_CLR_CHK:
            begin
               if (maze_rdata == `TILE_BOMB)
                  maze_wr <= '{we: 1'b1, addr: maze_raddr, code: `TILE_EMPTY};
               maze_raddr.flat <= maze_raddr.flat + 1'b1;
               if (maze_raddr.flat == `CLEAR_LAST)
                  state <= S_TBL_CLR;
               else
                  state <= S_CLR_WAIT;
            end
            // Zero every slot, read index doubles as the counter
            S_TBL_CLR:
            begin
               bomb_wr     <= '{we: 1'b1, slot: bomb_rd_idx, entry: '0};
               bomb_rd_idx <= bomb_rd_idx + 1'b1;
               if (bomb_rd_idx == SLOT_LAST)
                  state <= S_IDLE;
            end
            S_IDLE:
               if (eof)
                  state <= S_MV_BEGIN;
            // A moving player only steps, a resting one may start
            S_MV_BEGIN:
            begin
               if (cur_moving)
               begin
                  cmd_q.step <= 1'b1;
                  state      <= S_MV_NEXT;
               end
               else if (key_any)
               begin
                  cmd_q.start <= 1'b1;
                  cmd_q.dir   <= key_dir;
                  state       <= S_MV_GOAL;
               end
               else
                  state <= S_MV_NEXT;
            end
            // Goal tile settles in the player at the end of this cycle
            S_MV_GOAL:
               state <= S_MV_ADDR;
            S_MV_ADDR:
            begin
               maze_raddr.tile <= cur_goal;
               state           <= S_MV_WAIT;
            end
            S_MV_WAIT:
               state <= S_MV_CHK;
            S_MV_CHK:
            begin
               if (blocked)
                  cmd_q.cancel <= 1'b1;
               else
               begin
                  cmd_q.step <= 1'b1;
                  // Passed gate turns round
                  if (is_gate)
                     maze_wr <= '{we: 1'b1, addr: maze_raddr, code: flip_code};
               end
               state <= S_MV_NEXT;
            end
            // Strobe is still routed by pl here
            S_MV_NEXT:
            begin
               pl    <= !pl;
               state <= pl ? S_DR_BEGIN : S_MV_BEGIN;
            end
            S_DR_BEGIN:
            begin
               bomb_rd_idx <= '0;
               if (cur_pad.drop)
               begin
                  maze_raddr.tile <= drop_tile;
                  state           <= S_DR_WAIT;
               end
               else
                  state <= S_DR_NEXT;
            end
            S_DR_WAIT:
               state <= S_DR_CHK;
            S_DR_CHK:
            begin
               bomb_rd_idx <= bomb_rd_idx + 1'b1;
               state       <= (maze_rdata == `TILE_EMPTY) ? S_DR_SCAN : S_DR_NEXT;
            end
            // First free slot takes the bomb, a full table drops the request
            S_DR_SCAN:
            begin
               bomb_rd_idx <= bomb_rd_idx + 1'b1;
               if (bomb_rd_entry.fuse == '0)
               begin
                  bomb_wr <= '{we: 1'b1, slot: chk_idx,
                               entry: '{fuse: FUSE_FULL, addr: maze_raddr}};
                  maze_wr <= '{we: 1'b1, addr: maze_raddr, code: `TILE_BOMB};
                  state   <= S_DR_NEXT;
               end
               else if (chk_idx == SLOT_LAST)
                  state <= S_DR_NEXT;
            end
            S_DR_NEXT:
            begin
               pl          <= !pl;
               bomb_rd_idx <= '0;
               state       <= pl ? S_AGE_LEAD : S_DR_BEGIN;
            end
            S_AGE_LEAD:
            begin
               bomb_rd_idx <= bomb_rd_idx + 1'b1;
               state       <= S_AGE_SCAN;
            end
            // One slot per cycle, expired bombs leave maze and table
            S_AGE_SCAN:
            begin
               bomb_rd_idx <= bomb_rd_idx + 1'b1;
               if (bomb_rd_entry.fuse == FUSE_ONE)
               begin
                  maze_wr <= '{we: 1'b1, addr: bomb_rd_entry.addr, code: `TILE_EMPTY};
                  bomb_wr <= '{we: 1'b1, slot: chk_idx, entry: '0};
               end
               else if (bomb_rd_entry.fuse != '0)
                  bomb_wr <= '{we: 1'b1, slot: chk_idx,
                               entry: '{fuse: bomb_rd_entry.fuse - 1'b1,
                                        addr: bomb_rd_entry.addr}};
               if (chk_idx == SLOT_LAST)
                  state <= S_IDLE;
            end
            default:
               state <= S_IDLE;
         endcase
      end
   end

   // Goal tiles, drop tiles and stored bomb tiles all stay inside the sweep range
   assert property (@(posedge clk) disable iff (!reset_n)
      maze_wr.we |-> maze_wr.addr.flat <= `CLEAR_LAST);

   // Never two motion strobes at once, over both players
   assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0({p1_cmd.start, p1_cmd.cancel, p1_cmd.step,
                p2_cmd.start, p2_cmd.cancel, p2_cmd.step}));

endmodule

`default_nettype wire

/* hdl/bomb_table.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maze_consts.svh"

module bomb_table (
   input  wire                               clk,
   input  wire [$clog2(`BOMB_SLOTS)-1:0]     rd_idx,
   output maze_pkg::bomb_entry_t             rd_entry,
   input  wire maze_pkg::bomb_wr_t           wr
);

   import maze_pkg::*;

   // Fuse and maze tile of each live bomb, fuse zero marks a free slot
   bomb_entry_t mem [`BOMB_SLOTS];

   always_ff @(posedge clk)
   begin
      if (wr.we)
         mem[wr.slot] <= wr.entry;
   end

   // Registered read, entry follows rd_idx by one cycle
   always_ff @(posedge clk)
   begin
      rd_entry <= mem[rd_idx];
   end

   // Fresh drops carry the full fuse and aging only counts down
   assert property (@(posedge clk)
      wr.we |-> wr.entry.fuse <= `BOMB_FUSE);

endmodule

`default_nettype wire

/* hdl/player_motion.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maze_consts.svh"

module player_motion #(
   // Start position in pixels
   parameter int START_X = 0,
   parameter int START_Y = 0,
   // Sixteenths of a pixel per frame
   parameter int SPEED   = 16
) (
   input  wire                          clk,
   input  wire                          reset_n,
   input  wire maze_pkg::move_cmd_t     cmd,
   output maze_pkg::pos_t               pos,
   output logic                         moving,
   output maze_pkg::dir_t               dir,
   output maze_pkg::tile_pos_t          goal_tile
);

   import maze_pkg::*;

   localparam int FP_W    = `POS_W + `FRAC_BITS;
   // Fixed-point bit where the tile index starts
   localparam int TILE_SH = `FRAC_BITS + $clog2(`TILE_PX);
   localparam logic signed [FP_W-1:0] TILE_FP = FP_W'(`TILE_PX * (1 << `FRAC_BITS));
   localparam logic signed [FP_W-1:0] VEL     = FP_W'(SPEED);
   localparam logic signed [FP_W-1:0] X0      = FP_W'(START_X * (1 << `FRAC_BITS));
   localparam logic signed [FP_W-1:0] Y0      = FP_W'(START_Y * (1 << `FRAC_BITS));

   // Positions and goal in fixed point
   logic signed [FP_W-1:0] x_fp;
   logic signed [FP_W-1:0] y_fp;
   logic signed [FP_W-1:0] goal_x;
   logic signed [FP_W-1:0] goal_y;
   // Per-frame velocity, one axis nonzero while moving
   logic signed [FP_W-1:0] vx;
   logic signed [FP_W-1:0] vy;
   logic signed [FP_W-1:0] x_next;
   logic signed [FP_W-1:0] y_next;
   logic                   x_done;
   logic                   y_done;

   assign x_next = x_fp + vx;
   assign y_next = y_fp + vy;

   // Reaching or passing the goal on an axis, idle axis counts as done
   assign x_done = (vx == 0) || ((vx > 0) ? (x_next >= goal_x) : (x_next <= goal_x));
   assign y_done = (vy == 0) || ((vy > 0) ? (y_next >= goal_y) : (y_next <= goal_y));

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         x_fp   <= X0;
         y_fp   <= Y0;
         goal_x <= X0;
         goal_y <= Y0;
         vx     <= '0;
         vy     <= '0;
         moving <= 1'b0;
         dir    <= DIR_UP;
      end
      else if (cmd.start)
      begin
         // Goal one tile away along the requested axis
         dir    <= cmd.dir;
         moving <= 1'b1;
         goal_x <= x_fp;
         goal_y <= y_fp;
         vx     <= '0;
         vy     <= '0;
         case (cmd.dir)
            DIR_UP:
            begin
               goal_y <= y_fp - TILE_FP;
               vy     <= -VEL;
            end
            DIR_DOWN:
            begin
               goal_y <= y_fp + TILE_FP;
               vy     <= VEL;
            end
            DIR_LEFT:
            begin
               goal_x <= x_fp - TILE_FP;
               vx     <= -VEL;
            end
            default:
            begin
               goal_x <= x_fp + TILE_FP;
               vx     <= VEL;
            end
         endcase
      end
      else if (cmd.cancel)
      begin
         // Back to the tile we stand on
         goal_x <= x_fp;
         goal_y <= y_fp;
         vx     <= '0;
         vy     <= '0;
         moving <= 1'b0;
      end
      else if (cmd.step && moving)
      begin
         if (x_done && y_done)
         begin
            // Snap onto the goal, no overshoot
            x_fp   <= goal_x;
            y_fp   <= goal_y;
            moving <= 1'b0;
         end
         else
         begin
            x_fp <= x_next;
            y_fp <= y_next;
         end
      end
   end

   assign pos.x         = x_fp[FP_W-1:`FRAC_BITS];
   assign pos.y         = y_fp[FP_W-1:`FRAC_BITS];
   assign goal_tile.row = goal_y[TILE_SH +: `TILE_BITS];
   assign goal_tile.col = goal_x[TILE_SH +: `TILE_BITS];

   // Sequencer only starts a player that has come to rest
   assert property (@(posedge clk) disable iff (!reset_n)
      cmd.start |-> !moving);

endmodule

`default_nettype wire

/* hdl/maze_pkg.sv */
`default_nettype none

`include "maze_consts.svh"

package maze_pkg;

   // Tile coordinate, row in the upper bits
   typedef struct packed {
      logic [`TILE_BITS-1:0] row;
      logic [`TILE_BITS-1:0] col;
   } tile_pos_t;

   // Same maze word seen as a RAM address or as row and column
   typedef union packed {
      logic [2*`TILE_BITS-1:0] flat;
      tile_pos_t               tile;
   } tile_addr_u;

   // Pixel position of a player
   typedef struct packed {
      logic signed [`POS_W-1:0] x;
      logic signed [`POS_W-1:0] y;
   } pos_t;

   // Pad levels of one player
   typedef struct packed {
      logic up;
      logic down;
      logic left;
      logic right;
      logic drop;
   } pad_t;

   typedef enum logic [1:0] {
      DIR_UP,
      DIR_DOWN,
      DIR_LEFT,
      DIR_RIGHT
   } dir_t;

   // One-cycle strobes from the sequencer to a player
   typedef struct packed {
      logic start;
      dir_t dir;
      logic cancel;
      logic step;
   } move_cmd_t;

   // One slot of the bomb table
   typedef struct packed {
      logic [`FUSE_W-1:0] fuse;
      tile_addr_u         addr;
   } bomb_entry_t;

   typedef struct packed {
      logic                          we;
      logic [$clog2(`BOMB_SLOTS)-1:0] slot;
      bomb_entry_t                   entry;
   } bomb_wr_t;

   // Write strobe toward the maze RAM
   typedef struct packed {
      logic       we;
      tile_addr_u addr;
      logic [3:0] code;
   } maze_wr_t;

endpackage

`default_nettype wire

/* hdl/maze_consts.svh */
`ifndef MAZE_CONSTS_SVH
`define MAZE_CONSTS_SVH

// Maze size in tiles
`define MAZE_ROWS  17
`define MAZE_COLS  25

// Bits of one row or column index
`define TILE_BITS  5

// Tile edge in pixels
`define TILE_PX    32

// Sub-pixel fraction bits of a position
`define FRAC_BITS  4

// Width of one pixel coordinate, signed
`define POS_W      11

// Last flat address visited by the clear sweep (17 rows of 32 slots)
`define CLEAR_LAST 543

// Tile codes stored in the maze RAM
`define TILE_EMPTY 4'd0
`define TILE_WALL1 4'd1
`define TILE_WALL2 4'd2
`define GATE_RIGHT 4'd3
`define GATE_LEFT  4'd4
`define GATE_UP    4'd5
`define GATE_DOWN  4'd6
`define TILE_BOMB  4'd12

// Bomb bookkeeping
`define BOMB_SLOTS 16
`define BOMB_FUSE  360
`define FUSE_W     9

`endif
